// File: axis_mux_top.f
+incdir+tests
design/axis_pkg.sv
design/axis_skid.sv
design/axis_mux.sv
design/axis_mux_top.sv
tests/axis_mux_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the axis_mux testbench with Verilator and runs it.
# The result is taken from the simulation log.
set -e
cd "$(dirname "$0")"

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
    -f axis_mux_top.f \
    --top-module axis_mux_tb \
    -Mdir obj_dir

./obj_dir/Vaxis_mux_tb 2>&1 | tee "$log"

if grep -q "All tests passed!" "$log"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1

// File: tests/axis_mux_ref.svh
// One beat as the testbench tracks it from an input to the m output.
typedef struct packed {
    axis_pkg::axis_beat_t beat;
    logic [31:0]          cycle;    // Cycle on which the input accepted the beat.
    logic [3:0]           test_id;
} sent_beat_t;

// Beats accepted at s0 and s1 that have not yet reached the output.
sent_beat_t exp0[$];
sent_beat_t exp1[$];

function automatic string test_name(input logic [3:0] id);
    case (id)
        4'd1:    return "fixed_sel0";
        4'd2:    return "fixed_sel1";
        4'd3:    return "packet_integrity";
        4'd4:    return "back_pressure";
        4'd5:    return "single_beat";
        4'd6:    return "final";
        default: return "reset";
    endcase
endfunction

function automatic axis_pkg::axis_beat_t make_beat(input int data, input int keep, input bit last);
    axis_pkg::axis_beat_t b;
    b.data = data[axis_pkg::data_width-1:0];
    b.keep = keep[axis_pkg::keep_width-1:0];
    b.last = last;
    return b;
endfunction

// A new packet is taken only from the input that sel names, and only once
// that input has a packet at its head. The other input simply waits.
function automatic int next_source(input logic sel_held, input bit head0, input bit head1);
    if (!sel_held && head0) begin
        return 0;
    end
    if (sel_held && head1) begin
        return 1;
    end
    return -1;
endfunction

function automatic int exp_size(input int src);
    return (src == 0) ? exp0.size() : exp1.size();
endfunction

function automatic void exp_push(input int src, input sent_beat_t b);
    if (src == 0) begin
        exp0.push_back(b);
    end else begin
        exp1.push_back(b);
    end
endfunction

function automatic sent_beat_t exp_pop(input int src);
    return (src == 0) ? exp0.pop_front() : exp1.pop_front();
endfunction

// File: tests/axis_mux_tb.sv
`timescale 1ns/100ps

module axis_mux_tb;

    logic                 aclk;
    logic                 rst;
    logic                 sel;
    axis_pkg::axis_beat_t s0_beat;
    logic                 s0_valid;
    logic                 s0_ready;
    axis_pkg::axis_beat_t s1_beat;
    logic                 s1_valid;
    logic                 s1_ready;
    axis_pkg::axis_beat_t m_beat;
    logic                 m_valid;
    logic                 m_ready;

    integer      seed;
    logic [31:0] cycle;
    int          beats_loaded;
    int          beats_checked;
    int          mismatches;
    int          failures;
    bit          bp_on;
    bit          lat_check;
    bit          in_pkt;
    int          cur_src;
    logic        sel_d1;

    `include "axis_mux_ref.svh"

    // Beats waiting to be offered at each input.
    sent_beat_t tx0[$];
    sent_beat_t tx1[$];

    axis_mux_top uut (
        .aclk     (aclk),
        .rst      (rst),
        .sel      (sel),
        .s0_beat  (s0_beat),
        .s0_valid (s0_valid),
        .s0_ready (s0_ready),
        .s1_beat  (s1_beat),
        .s1_valid (s1_valid),
        .s1_ready (s1_ready),
        .m_beat   (m_beat),
        .m_valid  (m_valid),
        .m_ready  (m_ready)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic check_value(input logic [3:0] test_id, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s: expected %h, actual %h", test_name(test_id), what,
                     expected, actual);
            mismatches++;
        end
    endtask

    task automatic load_beat(input int src, input axis_pkg::axis_beat_t beat,
                             input logic [3:0] test_id);
        sent_beat_t b;
        b.beat    = beat;
        b.cycle   = '0;
        b.test_id = test_id;
        if (src == 0) begin
            tx0.push_back(b);
        end else begin
            tx1.push_back(b);
        end
        beats_loaded++;
    endtask

    task automatic load_packet(input int src, input int len, input logic [3:0] test_id);
        for (int i = 0; i < len; i++) begin
            load_beat(src, make_beat(rand_below(65536), rand_below(4), i == len - 1), test_id);
        end
    endtask

    function automatic bit side_idle(input int src);
        if (src == 0) begin
            return tx0.size() == 0 && exp_size(0) == 0 && !s0_valid;
        end
        return tx1.size() == 0 && exp_size(1) == 0 && !s1_valid;
    endfunction

    task automatic wait_drained(input int src);
        do begin
            @(posedge aclk);
        end while (!side_idle(src));
    endtask

    // Empties both inputs, leaving sel at 1.
    task automatic drain_all();
        sel <= 1'b0;
        wait_drained(0);
        sel <= 1'b1;
        wait_drained(1);
    endtask

    always @(posedge aclk) begin
        sent_beat_t b;
        if (rst) begin
            s0_valid <= 1'b0;
        end else begin
            if (s0_valid && s0_ready) begin
                b       = tx0.pop_front();
                b.cycle = cycle;
                exp_push(0, b);
            end
            if (tx0.size() > 0) begin
                s0_beat  <= tx0[0].beat;
                s0_valid <= 1'b1;
            end else begin
                s0_valid <= 1'b0;
            end
        end
    end

    always @(posedge aclk) begin
        sent_beat_t b;
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            if (s1_valid && s1_ready) begin
                b       = tx1.pop_front();
                b.cycle = cycle;
                exp_push(1, b);
            end
            if (tx1.size() > 0) begin
                s1_beat  <= tx1[0].beat;
                s1_valid <= 1'b1;
            end else begin
                s1_valid <= 1'b0;
            end
        end
    end

    always @(posedge aclk) begin
        if (bp_on) begin
            m_ready <= (rand_below(2) == 1);
        end else begin
            m_ready <= 1'b1;
        end
    end

    // The mux decides on the edge before the first beat reaches m, so the
    // reference uses sel as it stood one edge earlier.
    always @(posedge aclk) begin
        sent_beat_t want;
        int         src;
        if (rst) begin
            in_pkt = 1'b0;
            sel_d1 = sel;
        end else begin
            if (m_valid && m_ready) begin
                beats_checked++;
                if (in_pkt) begin
                    src = cur_src;
                end else begin
                    src = next_source(sel_d1, exp_size(0) > 0, exp_size(1) > 0);
                end
                if (src >= 0 && exp_size(src) == 0) begin
                    src = -1;
                end
                if (src < 0) begin
                    $display("Output beat with data %h arrived while no packet was waiting",
                             m_beat.data);
                    failures++;
                end else begin
                    want = exp_pop(src);
                    if (lat_check && !in_pkt) begin
                        check_value(want.test_id, "first beat latency", 32'd2,
                                    cycle - want.cycle);
                        lat_check = 1'b0;
                    end
                    check_value(want.test_id, "data", 32'(want.beat.data), 32'(m_beat.data));
                    check_value(want.test_id, "keep", 32'(want.beat.keep), 32'(m_beat.keep));
                    check_value(want.test_id, "last", 32'(want.beat.last), 32'(m_beat.last));
                    cur_src = src;
                    in_pkt  = !want.beat.last;
                end
            end
            sel_d1 = sel;
        end
    end

    // Each input path holds at most its skid buffer plus the output skid buffer.
    always @(negedge aclk) begin
        if (!rst && (exp_size(0) > 4 || exp_size(1) > 4)) begin
            $display("An input accepted a beat while its path was full (%0d and %0d in flight)",
                     exp_size(0), exp_size(1));
            failures++;
        end
    end

    initial begin
        @(negedge rst);
        while (cycle <= 100 + 20 * beats_loaded) begin
            @(posedge aclk);
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst           = 1'b1;
        sel           = 1'b0;
        s0_beat       = '0;
        s0_valid      = 1'b0;
        s1_beat       = '0;
        s1_valid      = 1'b0;
        m_ready       = 1'b1;
        seed          = 32'h1976;
        beats_loaded  = 0;
        beats_checked = 0;
        mismatches    = 0;
        failures      = 0;
        bp_on         = 1'b0;
        lat_check     = 1'b0;
        cur_src       = 0;

        for (int i = 0; i < 5; i++) begin
            @(posedge aclk);
            if (i > 0) begin
                check_value(4'd0, "m_valid in reset", 32'd0, 32'(m_valid));
            end
        end
        rst <= 1'b0;
        @(posedge aclk);
        check_value(4'd0, "m_valid after reset", 32'd0, 32'(m_valid));
        @(posedge aclk);
        check_value(4'd0, "s0_ready after reset", 32'd1, 32'(s0_ready));
        check_value(4'd0, "s1_ready after reset", 32'd1, 32'(s1_ready));
        check_value(4'd0, "m_valid idle", 32'd0, 32'(m_valid));

        sel       <= 1'b0;
        lat_check = 1'b1;
        for (int p = 0; p < 4; p++) begin
            load_packet(0, 1 + rand_below(8), 4'd1);
            load_packet(1, 1 + rand_below(8), 4'd1);
        end
        wait_drained(0);
        check_value(4'd1, "s1 beats held while unselected", 32'd2, 32'(exp_size(1)));
        sel <= 1'b1;
        for (int p = 0; p < 4; p++) begin
            load_packet(1, 1 + rand_below(8), 4'd2);
            load_packet(0, 1 + rand_below(8), 4'd2);
        end
        wait_drained(1);
        drain_all();

        sel <= 1'b0;
        repeat (2) @(posedge aclk);
        for (int i = 0; i < 4; i++) begin
            load_beat(0, make_beat(32'h3000 + i, 3, i == 3), 4'd3);
        end
        for (int p = 0; p < 3; p++) begin
            load_packet(1, 1 + rand_below(4), 4'd3);
        end
        do begin
            @(posedge aclk);
        end while (!(s0_valid && s0_ready && s0_beat.data == 16'h3001));
        sel <= 1'b1;  // Flips while the s0 packet is in flight.
        wait_drained(0);
        wait_drained(1);

        sel   <= 1'b0;
        bp_on = 1'b1;
        for (int p = 0; p < 6; p++) begin
            load_packet(0, 1 + rand_below(8), 4'd4);
            load_packet(1, 1 + rand_below(8), 4'd4);
        end
        wait_drained(0);
        sel <= 1'b1;
        wait_drained(1);
        bp_on = 1'b0;
        drain_all();

        for (int k = 0; k < 4; k++) begin
            sel <= k[0];
            load_beat(0, make_beat(32'h5000 + k, k, 1'b1), 4'd5);
            load_beat(1, make_beat(32'h5100 + k, k, 1'b1), 4'd5);
            wait_drained(k % 2);
        end
        drain_all();

        repeat (5) @(posedge aclk);
        check_value(4'd6, "beats out", 32'(beats_loaded), 32'(beats_checked));
        $display("Checked %0d beats: %0d value mismatches, %0d other failures",
                 beats_checked, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: design/axis_mux_top.sv
`timescale 1ns/100ps

module axis_mux_top (
    input  logic                 aclk,
    input  logic                 rst,
    input  logic                 sel,

    input  axis_pkg::axis_beat_t s0_beat,
    input  logic                 s0_valid,
    output logic                 s0_ready,

    input  axis_pkg::axis_beat_t s1_beat,
    input  logic                 s1_valid,
    output logic                 s1_ready,

    output axis_pkg::axis_beat_t m_beat,
    output logic                 m_valid,
    input  logic                 m_ready
);

    // Registered copies of the two input streams.
    axis_pkg::axis_beat_t s0q_beat;
    logic                 s0q_valid;
    logic                 s0q_ready;

    axis_pkg::axis_beat_t s1q_beat;
    logic                 s1q_valid;
    logic                 s1q_ready;

    // Mux output ahead of the output register.
    axis_pkg::axis_beat_t mux_beat;
    logic                 mux_valid;
    logic                 mux_ready;

    axis_skid s0_skid (
        .aclk      (aclk),
        .rst       (rst),
        .in_beat   (s0_beat),
        .in_valid  (s0_valid),
        .in_ready  (s0_ready),
        .out_beat  (s0q_beat),
        .out_valid (s0q_valid),
        .out_ready (s0q_ready)
    );

    axis_skid s1_skid (
        .aclk      (aclk),
        .rst       (rst),
        .in_beat   (s1_beat),
        .in_valid  (s1_valid),
        .in_ready  (s1_ready),
        .out_beat  (s1q_beat),
        .out_valid (s1q_valid),
        .out_ready (s1q_ready)
    );

    axis_mux mux (
        .aclk      (aclk),
        .rst       (rst),
        .sel       (sel),
        .in0_beat  (s0q_beat),
        .in0_valid (s0q_valid),
        .in0_ready (s0q_ready),
        .in1_beat  (s1q_beat),
        .in1_valid (s1q_valid),
        .in1_ready (s1q_ready),
        .out_beat  (mux_beat),
        .out_valid (mux_valid),
        .out_ready (mux_ready)
    );

    // Registers the output so m_beat and m_valid leave from flops.
    axis_skid out_skid (
        .aclk      (aclk),
        .rst       (rst),
        .in_beat   (mux_beat),
        .in_valid  (mux_valid),
        .in_ready  (mux_ready),
        .out_beat  (m_beat),
        .out_valid (m_valid),
        .out_ready (m_ready)
    );

endmodule

// File: design/axis_mux.sv
`timescale 1ns/100ps

module axis_mux (
    input  logic                 aclk,
    input  logic                 rst,
    input  logic                 sel,

    input  axis_pkg::axis_beat_t in0_beat,
    input  logic                 in0_valid,
    output logic                 in0_ready,

    input  axis_pkg::axis_beat_t in1_beat,
    input  logic                 in1_valid,
    output logic                 in1_ready,

    output axis_pkg::axis_beat_t out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);

    axis_pkg::mux_state_t state;
    axis_pkg::mux_state_t cur_state;
    axis_pkg::mux_state_t state_nxt;

    logic use_in1;
    logic out_xfer;

    // Effective state for this cycle.
    // In idle the owner comes straight from sel, so the first beat of a
    // packet passes without a bubble.
    always_comb begin
        if (state == axis_pkg::idle) begin
            cur_state = sel ? axis_pkg::pass1 : axis_pkg::pass0;
        end else begin
            cur_state = state;
        end
    end

    assign use_in1 = (cur_state == axis_pkg::pass1);

    // Zero-latency data path.
    always_comb begin
        if (use_in1) begin
            out_beat  = in1_beat;
            out_valid = in1_valid;
        end else begin
            out_beat  = in0_beat;
            out_valid = in0_valid;
        end
    end

    // Only the owning input sees the downstream ready.
    assign in0_ready = out_ready && !use_in1;
    assign in1_ready = out_ready && use_in1;

    assign out_xfer = out_valid && out_ready;

    always_comb begin
        state_nxt = state;

        if (out_xfer && out_beat.last) begin
            state_nxt = axis_pkg::idle;  // Packet done, sel is free to change the owner.
        end else if (out_valid) begin
            // A presented beat locks the owner, stalled or not, so the beat
            // seen by the next stage cannot be swapped underneath it.
            state_nxt = cur_state;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= axis_pkg::idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Never hand the output to both inputs at once.
    a_one_ready: assert property (
        @(posedge aclk) disable iff (rst)
        $onehot0({in0_ready, in1_ready})
    ) else $error("axis_mux: both input readies high");

    // A locked state is left only after the packet's last beat goes out.
    a_lock_held: assert property (
        @(posedge aclk) disable iff (rst)
        ((state != axis_pkg::idle) && !(out_xfer && out_beat.last)) |=> $stable(state)
    ) else $error("axis_mux: owner changed in the middle of a packet");

endmodule

// File: design/axis_skid.sv
`timescale 1ns/100ps

module axis_skid (
    input  logic                aclk,
    input  logic                rst,

    input  axis_pkg::axis_beat_t in_beat,
    input  logic                in_valid,
    output logic                in_ready,

    output axis_pkg::axis_beat_t out_beat,
    output logic                out_valid,
    input  logic                out_ready
);

    // The main register drives the output directly.
    // The spare register catches the one beat that can arrive after the
    // output stalls, because in_ready is registered and drops an edge late.
    axis_pkg::axis_beat_t spare_beat;
    logic                 spare_valid;

    logic in_xfer;
    logic main_free;
    logic spare_valid_nxt;

    always_comb begin
        in_xfer   = in_valid && in_ready;
        main_free = !out_valid || out_ready;  // Main is empty or is draining this edge.

        if (main_free) begin
            // Spare drains into main, or the new beat lands in main directly.
            spare_valid_nxt = 1'b0;
        end else begin
            spare_valid_nxt = spare_valid || in_xfer;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            spare_valid <= 1'b0;
            in_ready    <= 1'b0;  // Rises on the first edge out of reset.
        end else begin
            spare_valid <= spare_valid_nxt;
            in_ready    <= !spare_valid_nxt;  // Free entry left after this edge.

            if (main_free) begin
                out_valid <= spare_valid || in_xfer;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (main_free) begin
            if (spare_valid) begin
                out_beat <= spare_beat;  // Oldest beat goes out first.
            end else if (in_xfer) begin
                out_beat <= in_beat;
            end
        end

        if (!main_free && in_xfer) begin
            spare_beat <= in_beat;
        end
    end

    // A stalled beat must hold both its payload and its valid.
    a_out_stable: assert property (
        @(posedge aclk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    ) else $error("axis_skid: output beat changed while stalled");

    // With both registers full the buffer must refuse input.
    a_no_overfill: assert property (
        @(posedge aclk) disable iff (rst)
        (out_valid && spare_valid) |-> !(in_valid && in_ready)
    ) else $error("axis_skid: beat accepted with both entries full");

endmodule

// File: design/axis_pkg.sv
package axis_pkg;

    // Stream widths. Keep carries one bit per data byte.
    localparam int data_width = 16;
    localparam int keep_width = data_width / 8;

    // One beat of a stream, without its handshake bits.
    typedef struct packed {
        logic [data_width-1:0] data;  // Payload word.
        logic [keep_width-1:0] keep;  // Byte qualifiers, passed through untouched.
        logic                  last;  // High on the final beat of a packet.
    } axis_beat_t;

    // Packet-lock state of the two-input mux.
    // In idle no input owns the output and sel is decoded in the same cycle.
    // The two pass states hold the output on one input until a last beat transfers.
    typedef enum logic [1:0] {
        idle  = 2'd0,
        pass0 = 2'd1,
        pass1 = 2'd2
    } mux_state_t;

endpackage
